// ==== aluExec.sv ====
`timescale 1ns/1ps

module aluExec import datapathPkg::*; (
        input  logic                   clk,
        input  logic                   rstN,
        input  logic [dataWidth-1:0]   busIn,
        input  logic                   yIn,
        input  opcodeT                 opcode,
        output logic [2*dataWidth-1:0] aluResult
);

        logic [dataWidth-1:0]          yReg;
        logic [dataWidth-1:0]          a;
        logic [dataWidth-1:0]          b;
        logic [4:0]                    shAmt;
        logic signed [2*dataWidth-1:0] product;
        logic signed [dataWidth-1:0]   quot;
        logic signed [dataWidth-1:0]   rem;
        logic [2*dataWidth-1:0]        rorWord;
        logic [2*dataWidth-1:0]        rolWord;

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        yReg <= '0;
                end else if (yIn) begin
                        yReg <= busIn;
                end
        end

        assign a     = yReg;    // Operand A from Y
        assign b     = busIn;   // Operand B straight off the bus
        assign shAmt = b[4:0];

        assign product = $signed({{dataWidth{a[dataWidth-1]}}, a}) *
                         $signed({{dataWidth{b[dataWidth-1]}}, b});

        // Divide by zero gives all ones and keeps A as remainder
        assign quot = (b == '0) ? $signed({dataWidth{1'b1}}) : $signed(a) / $signed(b);
        assign rem  = (b == '0) ? $signed(a) : $signed(a) % $signed(b);

        // Rotates taken from a doubled word
        assign rorWord = {a, a} >> shAmt;
        assign rolWord = {a, a} << shAmt;

        always_comb begin
                aluResult = '0;
                case (opcode)
                        opAdd:  aluResult[dataWidth-1:0] = a + b;
                        opSub:  aluResult[dataWidth-1:0] = a - b;
                        opMul:  aluResult = product;
                        opDiv:  aluResult = {rem, quot};
                        opShr:  aluResult[dataWidth-1:0] = a >> shAmt;
                        opShl:  aluResult[dataWidth-1:0] = a << shAmt;
                        opShra: aluResult[dataWidth-1:0] = $signed(a) >>> shAmt;
                        opRor:  aluResult[dataWidth-1:0] = rorWord[dataWidth-1:0];
                        opRol:  aluResult[dataWidth-1:0] = rolWord[2*dataWidth-1:dataWidth];
                        opAnd:  aluResult[dataWidth-1:0] = a & b;
                        opOr:   aluResult[dataWidth-1:0] = a | b;
                        opNeg:  aluResult[dataWidth-1:0] = '0 - b;
                        opXor:  aluResult[dataWidth-1:0] = a ^ b;
                        opNor:  aluResult[dataWidth-1:0] = ~(a | b);
                        opNot:  aluResult[dataWidth-1:0] = ~b;
                        default: aluResult = '0;    // Unused opcodes
                endcase
        end

endmodule

// ==== cpuDatapath.sv ====
`timescale 1ns/1ps

module cpuDatapath import datapathPkg::*; (
        input  logic                 clk,
        input  logic                 rstN,
        input  logic                 read,
        input  logic                 write,
        input  logic                 baOut,
        input  logic                 rIn,
        input  logic                 rOut,
        input  logic                 gra,
        input  logic                 grb,
        input  logic                 grc,
        input  logic                 marIn,
        input  logic                 mdrIn,
        input  logic                 hiIn,
        input  logic                 loIn,
        input  logic                 yIn,
        input  logic                 zIn,
        input  logic                 pcIn,
        input  logic                 irIn,
        input  logic                 incPc,
        input  logic                 inPortIn,
        input  logic                 outPortIn,
        input  logic                 hiOut,
        input  logic                 loOut,
        input  logic                 zHighOut,
        input  logic                 zLowOut,
        input  logic                 mdrOut,
        input  logic                 pcOut,
        input  logic                 inPortOut,
        input  logic                 cOut,
        input  logic [4:0]           opcode,
        input  logic [dataWidth-1:0] inPortData,
        output logic [dataWidth-1:0] busData,
        output logic [dataWidth-1:0] outPortData
);

        logic [dataWidth-1:0]   pc;
        logic [dataWidth-1:0]   constC;
        logic [dataWidth-1:0]   regData;
        logic [2*dataWidth-1:0] aluResult;
        logic [dataWidth-1:0]   zHigh;
        logic [dataWidth-1:0]   zLow;
        logic [dataWidth-1:0]   hi;
        logic [dataWidth-1:0]   lo;
        logic [dataWidth-1:0]   mdr;
        logic [dataWidth-1:0]   inPort;
        busSrcT                 busSrc;

        regSelIf sel ();

        instrDecode decodeInst (
                .clk(clk), .rstN(rstN), .busIn(busData), .irIn(irIn),
                .gra(gra), .grb(grb), .grc(grc),
                .rIn(rIn), .rOut(rOut), .baOut(baOut),
                .constC(constC), .sel(sel.decode)
        );

        regFile regFileInst (
                .clk(clk), .rstN(rstN), .busIn(busData), .regData(regData), .sel(sel.regs)
        );

        aluExec aluInst (
                .clk(clk), .rstN(rstN), .busIn(busData), .yIn(yIn),
                .opcode(opcodeT'(opcode)), .aluResult(aluResult)
        );

        resultRegs resultInst (
                .clk(clk), .rstN(rstN), .busIn(busData), .aluResult(aluResult),
                .zIn(zIn), .hiIn(hiIn), .loIn(loIn),
                .zHigh(zHigh), .zLow(zLow), .hi(hi), .lo(lo)
        );

        memUnit memInst (
                .clk(clk), .rstN(rstN), .busIn(busData),
                .marIn(marIn), .mdrIn(mdrIn), .read(read), .write(write),
                .inPortIn(inPortIn), .outPortIn(outPortIn), .inPortData(inPortData),
                .mdr(mdr), .inPort(inPort), .outPortData(outPortData)
        );

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        pc <= '0;
                end else if (pcIn) begin
                        pc <= busData;      // Jump value wins over increment
                end else if (incPc) begin
                        pc <= pc + 1'b1;
                end
        end

        // Only one out strobe is expected per cycle
        always_comb begin
                if (rOut || baOut)  busSrc = srcReg;
                else if (hiOut)     busSrc = srcHi;
                else if (loOut)     busSrc = srcLo;
                else if (zHighOut)  busSrc = srcZHigh;
                else if (zLowOut)   busSrc = srcZLow;
                else if (pcOut)     busSrc = srcPc;
                else if (mdrOut)    busSrc = srcMdr;
                else if (inPortOut) busSrc = srcInPort;
                else if (cOut)      busSrc = srcC;
                else                busSrc = srcNone;
        end

        always_comb begin
                case (busSrc)
                        srcReg:    busData = regData;
                        srcHi:     busData = hi;
                        srcLo:     busData = lo;
                        srcZHigh:  busData = zHigh;
                        srcZLow:   busData = zLow;
                        srcPc:     busData = pc;
                        srcMdr:    busData = mdr;
                        srcInPort: busData = inPort;
                        srcC:      busData = constC;
                        default:   busData = '0;    // Idle bus
                endcase
        end

endmodule

// ==== datapathPkg.sv ====
package datapathPkg;

        localparam int dataWidth    = 32;
        localparam int regCount     = 16;
        localparam int regIdxWidth  = 4;
        localparam int memDepth     = 512;
        localparam int memAddrWidth = 9;

        // Register fields and constant of the instruction word
        localparam int raLsb      = 23;
        localparam int rbLsb      = 19;
        localparam int rcLsb      = 15;
        localparam int constWidth = 19;

        typedef enum logic [4:0] {
                opAdd  = 5'd1,
                opSub  = 5'd2,
                opMul  = 5'd3,
                opDiv  = 5'd4,
                opShr  = 5'd5,
                opShl  = 5'd6,
                opShra = 5'd7,
                opRor  = 5'd8,
                opRol  = 5'd9,
                opAnd  = 5'd10,
                opOr   = 5'd11,
                opNeg  = 5'd12,
                opXor  = 5'd13,
                opNor  = 5'd14,
                opNot  = 5'd15
        } opcodeT;

        typedef enum logic [3:0] {
                srcNone, srcReg, srcHi, srcLo, srcZHigh, srcZLow, srcPc, srcMdr, srcInPort, srcC
        } busSrcT;

endpackage

// ==== instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode import datapathPkg::*; (
        input  logic                 clk,
        input  logic                 rstN,
        input  logic [dataWidth-1:0] busIn,
        input  logic                 irIn,
        input  logic                 gra,
        input  logic                 grb,
        input  logic                 grc,
        input  logic                 rIn,
        input  logic                 rOut,
        input  logic                 baOut,
        output logic [dataWidth-1:0] constC,
        regSelIf.decode              sel
);

        logic [dataWidth-1:0] ir;

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        ir <= '0;
                end else if (irIn) begin
                        ir <= busIn;
                end
        end

        // Field picked by whichever gr strobe is up
        always_comb begin
                if (gra)
                        sel.regIdx = ir[raLsb +: regIdxWidth];
                else if (grb)
                        sel.regIdx = ir[rbLsb +: regIdxWidth];
                else if (grc)
                        sel.regIdx = ir[rcLsb +: regIdxWidth];
                else
                        sel.regIdx = '0;
        end

        assign sel.writeEn  = rIn;
        assign sel.readEn   = rOut | baOut;
        assign sel.baseZero = baOut;

        // Sign extended C field for cOut
        assign constC = {{(dataWidth - constWidth){ir[constWidth-1]}}, ir[constWidth-1:0]};

endmodule

// ==== memUnit.sv ====
`timescale 1ns/1ps

module memUnit import datapathPkg::*; (
        input  logic                 clk,
        input  logic                 rstN,
        input  logic [dataWidth-1:0] busIn,
        input  logic                 marIn,
        input  logic                 mdrIn,
        input  logic                 read,
        input  logic                 write,
        input  logic                 inPortIn,
        input  logic                 outPortIn,
        input  logic [dataWidth-1:0] inPortData,
        output logic [dataWidth-1:0] mdr,
        output logic [dataWidth-1:0] inPort,
        output logic [dataWidth-1:0] outPortData
);

        logic [memAddrWidth-1:0] mar;
        logic [dataWidth-1:0]    mem [memDepth];

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        mar         <= '0;
                        mdr         <= '0;
                        inPort      <= '0;
                        outPortData <= '0;
                end else begin
                        if (marIn)
                                mar <= busIn[memAddrWidth-1:0];    // Word address only
                        if (mdrIn)
                                mdr <= read ? mem[mar] : busIn;
                        if (inPortIn)
                                inPort <= inPortData;
                        if (outPortIn)
                                outPortData <= busIn;
                end
        end

        // Memory keeps its contents through reset
        always_ff @(posedge clk) begin
                if (write) begin
                        mem[mar] <= mdr;
                end
        end

endmodule

// ==== project.f ====
datapathPkg.sv
regSelIf.sv
instrDecode.sv
regFile.sv
aluExec.sv
resultRegs.sv
memUnit.sv
cpuDatapath.sv
tbDatapath_props.sv
tbDatapath.sv

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile import datapathPkg::*; (
        input  logic                 clk,
        input  logic                 rstN,
        input  logic [dataWidth-1:0] busIn,
        output logic [dataWidth-1:0] regData,
        regSelIf.regs                sel
);

        logic [dataWidth-1:0] regs [regCount];

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        for (int i = 0; i < regCount; i++) begin
                                regs[i] <= '0;
                        end
                end else if (sel.writeEn) begin
                        regs[sel.regIdx] <= busIn;
                end
        end

        // R0 under baOut acts as a zero base address
        always_comb begin
                if (!sel.readEn)
                        regData = '0;
                else if (sel.baseZero && sel.regIdx == '0)
                        regData = '0;
                else
                        regData = regs[sel.regIdx];
        end

endmodule

// ==== regSelIf.sv ====
`timescale 1ns/1ps

// Register select and strobes from decode into the register file
interface regSelIf import datapathPkg::*; ();

        logic [regIdxWidth-1:0] regIdx;
        logic                   writeEn;
        logic                   readEn;
        logic                   baseZero;     // baOut active, R0 reads as zero

        modport decode (
                output regIdx, writeEn, readEn, baseZero
        );

        modport regs (
                input regIdx, writeEn, readEn, baseZero
        );

endinterface

// ==== resultRegs.sv ====
`timescale 1ns/1ps

module resultRegs import datapathPkg::*; (
        input  logic                   clk,
        input  logic                   rstN,
        input  logic [dataWidth-1:0]   busIn,
        input  logic [2*dataWidth-1:0] aluResult,
        input  logic                   zIn,
        input  logic                   hiIn,
        input  logic                   loIn,
        output logic [dataWidth-1:0]   zHigh,
        output logic [dataWidth-1:0]   zLow,
        output logic [dataWidth-1:0]   hi,
        output logic [dataWidth-1:0]   lo
);

        logic [2*dataWidth-1:0] zReg;

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        zReg <= '0;
                        hi   <= '0;
                        lo   <= '0;
                end else begin
                        if (zIn) zReg <= aluResult;
                        if (hiIn) hi <= busIn;      // HI and LO fill from the bus
                        if (loIn) lo <= busIn;
                end
        end

        assign zHigh = zReg[2*dataWidth-1:dataWidth];
        assign zLow  = zReg[dataWidth-1:0];

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the datapath testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbDatapath -f project.f -o simDatapath
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

simOut=$(./obj_dir/simDatapath)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
        echo "Simulation exited with status $simStatus"
        exit 1
fi

if echo "$simOut" | grep -qx "ALL TESTS PASSED"; then
        exit 0
fi
exit 1

// ==== tbDatapath.sv ====
`timescale 1ns/1ps

module tbDatapath import datapathPkg::*; ();

        localparam int cycleLimit = 2000;    // Tests need roughly 600 cycles

        logic        clk;
        logic        rstN;
        logic        read, write, baOut, rIn, rOut, gra, grb, grc;
        logic        marIn, mdrIn, hiIn, loIn, yIn, zIn, pcIn, irIn;
        logic        incPc, inPortIn, outPortIn, hiOut, loOut, zHighOut, zLowOut;
        logic        mdrOut, pcOut, inPortOut, cOut;
        logic [4:0]  opcode;
        logic [31:0] inPortData;
        logic [31:0] busData;
        logic [31:0] outPortData;

        // Reference model state
        logic [31:0] modelReg [16];
        logic [31:0] modelMem [512];
        logic [31:0] modelPc;
        logic [31:0] modelOut;
        logic [63:0] modelZ;

        string       testName;
        int          errCount;
        int          checkCount;
        int          testCount;
        int          failedTests;
        int          testErrStart;
        int          cycles;

        cpuDatapath cpuDatapath_inst (.*);

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        task automatic clearStrobes();
                {read, write, baOut, rIn, rOut, gra, grb, grc} = 8'b0;
                {marIn, mdrIn, hiIn, loIn, yIn, zIn, pcIn, irIn} = 8'b0;
                {incPc, inPortIn, outPortIn, hiOut, loOut, zHighOut, zLowOut} = 7'b0;
                {mdrOut, pcOut, inPortOut, cOut} = 4'b0;
                opcode = 5'b0;
        endtask

        // Strobes take effect at the coming edge, then drop 1 ns after it
        task automatic cycleEnd();
                @(posedge clk);
                #1;
                clearStrobes();
        endtask

        task automatic checkVal(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
                checkCount++;
                assert (act === exp) else begin
                        $display("ERR %s %s: expected %h, actual %h", testName, what, exp, act);
                        errCount++;
                end
        endtask

        task automatic busIs(input string what, input logic [31:0] exp);
                #2;    // Let the bus settle inside the cycle
                checkVal(what, exp, busData);
        endtask

        task automatic startTest(input string name);
                testName     = name;
                testErrStart = errCount;
                testCount++;
        endtask

        task automatic endTest();
                if (errCount == testErrStart) begin
                        $display("test %s: pass", testName);
                end else begin
                        $display("test %s: fail, %0d errors", testName, errCount - testErrStart);
                        failedTests++;
                end
        endtask

        function automatic logic [31:0] makeInstr(input logic [4:0] op, input logic [3:0] ra,
                                                  input logic [3:0] rb, input logic [3:0] rc);
                makeInstr = {op, ra, rb, rc, 15'b0};
        endfunction

        // Expected 64 bit result of A op B, following the opcode rules
        function automatic logic [63:0] expectAlu(input logic [4:0] op, input logic [31:0] a,
                                                  input logic [31:0] b);
                int          sa;
                int          sb;
                longint      la;
                longint      lq;
                logic [31:0] r;
                logic [4:0]  s;
                sa = a;
                sb = b;
                s  = b[4:0];
                r  = a;
                expectAlu = 64'b0;
                case (op)
                        opAdd: expectAlu = {32'b0, a + b};
                        opSub: expectAlu = {32'b0, a - b};
                        opMul: begin
                                la = longint'(sa) * longint'(sb);
                                expectAlu = la;
                        end
                        opDiv: begin
                                if (b == 32'b0) begin
                                        expectAlu = {a, 32'hFFFF_FFFF};
                                end else begin
                                        lq = longint'(sa) / longint'(sb);
                                        la = longint'(sa) - lq * longint'(sb);
                                        expectAlu = {la[31:0], lq[31:0]};
                                end
                        end
                        opShr: expectAlu = {32'b0, a >> s};
                        opShl: expectAlu = {32'b0, a << s};
                        opShra: begin
                                la = longint'(sa) >>> s;
                                expectAlu = {32'b0, la[31:0]};
                        end
                        opRor: begin
                                repeat (s) r = {r[0], r[31:1]};
                                expectAlu = {32'b0, r};
                        end
                        opRol: begin
                                repeat (s) r = {r[30:0], r[31]};
                                expectAlu = {32'b0, r};
                        end
                        opAnd: expectAlu = {32'b0, a & b};
                        opOr:  expectAlu = {32'b0, a | b};
                        opNeg: expectAlu = {32'b0, 32'b0 - b};
                        opXor: expectAlu = {32'b0, a ^ b};
                        opNor: expectAlu = {32'b0, ~(a | b)};
                        opNot: expectAlu = {32'b0, ~b};
                        default: expectAlu = 64'b0;
                endcase
        endfunction

        task automatic setInPort(input logic [31:0] v);
                inPortData = v;
                inPortIn   = 1'b1;
                cycleEnd();
        endtask

        task automatic loadIr(input logic [31:0] instr);
                setInPort(instr);
                inPortOut = 1'b1;
                irIn      = 1'b1;
                busIs("ir load", instr);
                cycleEnd();
        endtask

        task automatic loadMar(input logic [8:0] addr);
                setInPort({23'b0, addr});
                inPortOut = 1'b1;
                marIn     = 1'b1;
                cycleEnd();
        endtask

        task automatic writeMem(input logic [8:0] addr, input logic [31:0] data);
                loadMar(addr);
                setInPort(data);
                inPortOut = 1'b1;
                mdrIn     = 1'b1;
                cycleEnd();
                write = 1'b1;
                cycleEnd();
                modelMem[addr] = data;
        endtask

        task automatic readMem(input logic [8:0] addr);
                loadMar(addr);
                read  = 1'b1;
                mdrIn = 1'b1;
                cycleEnd();
                mdrOut = 1'b1;
                busIs("mdr", modelMem[addr]);
                cycleEnd();
        endtask

        // Reads the register picked by field 0 (Ra), 1 (Rb) or 2 (Rc)
        task automatic readReg(input int field, input logic [3:0] idx);
                gra  = (field == 0);
                grb  = (field == 1);
                grc  = (field == 2);
                rOut = 1'b1;
                busIs($sformatf("R%0d", idx), modelReg[idx]);
                cycleEnd();
        endtask

        task automatic runAlu(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b);
                setInPort(a);
                inPortOut = 1'b1;
                yIn       = 1'b1;
                cycleEnd();
                setInPort(b);
                inPortOut = 1'b1;
                zIn       = 1'b1;
                opcode    = op;
                cycleEnd();
                modelZ = expectAlu(op, a, b);
                zLowOut = 1'b1;
                busIs($sformatf("op %0d zLow", op), modelZ[31:0]);
                cycleEnd();
                zHighOut = 1'b1;
                busIs($sformatf("op %0d zHigh", op), modelZ[63:32]);
                cycleEnd();
        endtask

        initial begin
                while (cycles < cycleLimit) begin
                        @(posedge clk);
                        cycles++;
                end
                $display("Timeout: run went past %0d cycles without finishing", cycleLimit);
                $display("SOME TESTS FAILED");
                $finish;
        end

        initial begin
                logic [31:0] v;
                logic [31:0] r;
                logic [3:0]  ri;
                logic [8:0]  addrs [8];
                void'($urandom(32'he843_3a1a));
                rstN       = 1'b0;
                inPortData = 32'b0;
                clearStrobes();
                for (int i = 0; i < 16; i++) begin
                        modelReg[i] = 32'b0;
                end
                modelPc  = 32'b0;
                modelOut = 32'b0;
                repeat (2) @(posedge clk);
                #1;
                rstN = 1'b1;

                startTest("resetOutPort");
                checkVal("bus after reset", 32'b0, busData);
                checkVal("out port after reset", 32'b0, outPortData);
                v = $urandom;
                setInPort(v);
                inPortOut = 1'b1;
                outPortIn = 1'b1;
                busIs("in port on bus", v);
                cycleEnd();
                modelOut = v;
                checkVal("out port", modelOut, outPortData);
                endTest();

                startTest("regTransfer");
                for (int i = 0; i < 16; i++) begin
                        ri = i[3:0];
                        v  = $urandom;
                        if (i == 0) v = v | 32'h1;    // Nonzero R0 so baOut shows the zero base
                        loadIr(makeInstr(5'd0, ri, ri + 4'd1, ri + 4'd2));
                        setInPort(v);
                        inPortOut = 1'b1;
                        gra       = 1'b1;
                        rIn       = 1'b1;
                        cycleEnd();
                        modelReg[ri] = v;
                end
                for (int i = 0; i < 16; i++) begin
                        ri = i[3:0];
                        loadIr(makeInstr(5'd0, ri, ri + 4'd1, ri + 4'd2));
                        readReg(0, ri);
                        readReg(1, ri + 4'd1);
                        readReg(2, ri + 4'd2);
                end
                loadIr(makeInstr(5'd0, 4'd0, 4'd0, 4'd0));
                gra   = 1'b1;
                baOut = 1'b1;
                busIs("R0 under baOut", 32'b0);
                cycleEnd();
                readReg(0, 4'd0);
                endTest();

                startTest("memory");
                for (int k = 0; k < 8; k++) begin
                        r        = $urandom;
                        addrs[k] = r[8:0];
                        writeMem(addrs[k], $urandom);
                end
                for (int k = 0; k < 8; k++) begin
                        readMem(addrs[k]);
                end
                endTest();

                startTest("alu");
                for (int op = 1; op <= 15; op++) begin
                        runAlu(op[4:0], $urandom, $urandom);
                end
                runAlu(opDiv, $urandom, 32'b0);
                for (int op = 5; op <= 9; op++) begin
                        r = $urandom;
                        runAlu(op[4:0], $urandom, {r[31:5], 5'd0});
                        runAlu(op[4:0], $urandom, {r[31:5], 5'd31});
                end
                runAlu(5'd0, $urandom, $urandom);    // Unused codes give zero
                runAlu(5'd22, $urandom, $urandom);
                runAlu(opMul, $urandom, $urandom);
                zHighOut = 1'b1;
                hiIn     = 1'b1;
                cycleEnd();
                zLowOut = 1'b1;
                loIn    = 1'b1;
                cycleEnd();
                hiOut = 1'b1;
                busIs("hi", modelZ[63:32]);
                cycleEnd();
                loOut = 1'b1;
                busIs("lo", modelZ[31:0]);
                cycleEnd();
                endTest();

                startTest("loadInstr");
                v = makeInstr(5'd0, 4'd2, 4'd0, 4'd0) | 32'h75;    // ld R2, 0x75(R0)
                writeMem(9'h075, 32'hFF00_FF00);
                writeMem(9'h000, v);
                setInPort(32'b0);
                inPortOut = 1'b1;
                pcIn      = 1'b1;
                cycleEnd();
                modelPc = 32'b0;
                pcOut = 1'b1;
                marIn = 1'b1;
                incPc = 1'b1;
                busIs("fetch pc", modelPc);
                cycleEnd();
                modelPc = modelPc + 1;
                read  = 1'b1;
                mdrIn = 1'b1;
                cycleEnd();
                mdrOut = 1'b1;
                irIn   = 1'b1;
                busIs("fetched instr", v);
                cycleEnd();
                grb   = 1'b1;
                baOut = 1'b1;
                yIn   = 1'b1;
                busIs("base R0", 32'b0);
                cycleEnd();
                cOut   = 1'b1;
                zIn    = 1'b1;
                opcode = opAdd;
                busIs("constant", 32'h75);
                cycleEnd();
                zLowOut = 1'b1;
                marIn   = 1'b1;
                busIs("address", 32'h75);
                cycleEnd();
                read  = 1'b1;
                mdrIn = 1'b1;
                cycleEnd();
                mdrOut = 1'b1;
                gra    = 1'b1;
                rIn    = 1'b1;
                busIs("loaded word", modelMem[9'h075]);
                cycleEnd();
                modelReg[2] = modelMem[9'h075];
                readReg(0, 4'd2);
                pcOut = 1'b1;
                busIs("pc after fetch", modelPc);
                cycleEnd();
                endTest();

                $display("%0d tests, %0d failed, %0d checks, %0d errors",
                         testCount, failedTests, checkCount, errCount);
                if (errCount == 0)
                        $display("ALL TESTS PASSED");
                else
                        $display("SOME TESTS FAILED");
                $finish;
        end

endmodule

// ==== tbDatapath_props.sv ====
`timescale 1ns/1ps

module datapathProps (
        input logic        clk,
        input logic        rstN,
        input logic [9:0]  outStrobes,
        input logic        incPc,
        input logic        pcIn,
        input logic        zIn,
        input logic [31:0] pc,
        input logic [63:0] aluResult,
        input logic [31:0] zHigh,
        input logic [31:0] zLow,
        input logic [31:0] outPortData
);

        // Single bus driver per cycle
        oneDriver: assert property (@(posedge clk) disable iff (!rstN) $onehot0(outStrobes))
                else $error("more than one bus out strobe high");

        pcStep: assert property (@(posedge clk) disable iff (!rstN)
                (incPc && !pcIn) |=> pc == $past(pc) + 32'd1)
                else $error("incPc did not advance the PC by one");

        zLoad: assert property (@(posedge clk) disable iff (!rstN)
                zIn |=> {zHigh, zLow} == $past(aluResult))
                else $error("Z does not hold the ALU result after zIn");

        outReset: assert property (@(posedge clk) !rstN |=> outPortData == '0)
                else $error("out port not cleared by reset");

endmodule

bind cpuDatapath datapathProps propsInst (
        .clk(clk), .rstN(rstN),
        .outStrobes({rOut, baOut, hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut,
                     inPortOut, cOut}),
        .incPc(incPc), .pcIn(pcIn), .zIn(zIn), .pc(pc), .aluResult(aluResult),
        .zHigh(zHigh), .zLow(zLow), .outPortData(outPortData)
);
